/* Makefile */
BIN := obj_dir/Vooo_core_tb
SRCS := $(shell grep -v '^+' src.f) source/ooo_settings.svh

.PHONY: all run clean

all: run

$(BIN): src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb -f src.f

run: $(BIN)
	-$(BIN) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "simulation reported an error"; exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log || (echo "simulation stopped early"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* dv/ooo_core_assertions.sv */
`default_nettype none

`include "ooo_settings.svh"

module ooo_core_assertions import ooo_pkg::*; (
	input logic    clk,
	input logic    arst_n,
	input logic    load_ready,
	input commit_t commit,
	input logic    commit_valid,
	input logic    commit_ready,
	input logic    done,
	input mode_t   mode_q,
	input cdb_t    cdb
);

	////////////////////////////////////////////////////////////////////////////
	// reset state
	////////////////////////////////////////////////////////////////////////////

	reset_state: assert property (@(posedge clk)
		!arst_n |-> !load_ready && !commit_valid && !done && !cdb.valid &&
			mode_q == MODE_LOAD)
		else $error("core left its reset state while reset was held");

	////////////////////////////////////////////////////////////////////////////
	// handshakes
	////////////////////////////////////////////////////////////////////////////

	commit_held: assert property (@(posedge clk) disable iff (!arst_n)
		commit_valid && !commit_ready |=> commit_valid && $stable(commit))
		else $error("commit dropped or changed before its transfer");

	done_is_idle: assert property (@(posedge clk) disable iff (!arst_n)
		done |-> !cdb.valid)
		else $error("done high while a result is still on the bus");

endmodule

bind ooo_core ooo_core_assertions ooo_core_assertions_i (
	.clk,
	.arst_n,
	.load_ready,
	.commit,
	.commit_valid,
	.commit_ready,
	.done,
	.mode_q,
	.cdb
);

`default_nettype wire

/* dv/ooo_core_tb.sv */
`default_nettype none

`include "ooo_settings.svh"

module ooo_core_tb import ooo_pkg::*; ();

	localparam int RUN_LIMIT  = 20000;
	localparam int WAIT_LIMIT = 50;

	logic    clk;
	logic    arst_n;
	inst_t   load_inst;
	logic    load_valid;
	logic    load_ready;
	logic    run;
	commit_t commit;
	logic    commit_valid;
	logic    commit_ready;
	logic    done;

	// in-order reference state
	data_t   model_regs [`OOO_REG_COUNT];
	inst_t   program_q [$];
	commit_t expect_q [$];
	int      commit_count;
	int      expected_total;

	ooo_core ooo_core_i (
		.clk,
		.arst_n,
		.load_inst,
		.load_valid,
		.load_ready,
		.run,
		.commit,
		.commit_valid,
		.commit_ready,
		.done
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		assert (actual === expected) else begin
			stop_with_error($sformatf("CHECK FAILED at time %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// program generation and in-order model
	////////////////////////////////////////////////////////////////////////////

	task automatic build_program(input int count);
		inst_t    ins;
		commit_t  exp;
		reg_idx_t prev_rd;
		program_q.delete();
		expect_q.delete();
		prev_rd = '0;
		for (int i = 0; i < count; i++) begin
			ins     = '0;
			ins.op  = opcode_t'($urandom_range(0, 2));
			ins.rd  = reg_idx_t'($urandom_range(0, 7));
			ins.rs  = reg_idx_t'($urandom_range(0, 7));
			ins.rt  = reg_idx_t'($urandom_range(0, 7));
			ins.imm = 16'($urandom);
			// lean on the previous result for dependency chains
			if ($urandom_range(0, 1) == 1) begin
				ins.rs = prev_rd;
			end
			if ($urandom_range(0, 3) == 0) begin
				ins.rt = prev_rd;
			end
			exp.rd = ins.rd;
			case (ins.op)
				OP_ADD:  exp.data = model_regs[ins.rs] + model_regs[ins.rt];
				OP_SUB:  exp.data = model_regs[ins.rs] - model_regs[ins.rt];
				default: exp.data = model_regs[ins.rs] + data_t'($signed(ins.imm));
			endcase
			model_regs[ins.rd] = exp.data;
			prev_rd            = ins.rd;
			program_q.push_back(ins);
			expect_q.push_back(exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// load, run and wait
	////////////////////////////////////////////////////////////////////////////

	task automatic load_program();
		foreach (program_q[i]) begin
			check_value("load_ready", load_ready, 1'b1);
			load_inst  = program_q[i];
			load_valid = 1'b1;
			@(negedge clk);
		end
		load_valid = 1'b0;
		load_inst  = '0;
	endtask

	task automatic wait_for_load_ready();
		int cycles;
		cycles = 0;
		while (!load_ready && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!load_ready) begin
			stop_with_error("load_ready never rose after returning to load mode");
		end
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (!done && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			stop_with_error("program did not finish, done never rose");
		end
	endtask

	task automatic execute_program();
		commit_count   = 0;
		expected_total = expect_q.size();
		run            = 1'b1;
		@(negedge clk);
		// fetch cycle
		check_value("done", done, 1'b0);
		check_value("load_ready", load_ready, 1'b0);
		wait_for_done();
		check_value("commit count", commit_count, expected_total);
	endtask

	// commit back-pressure and comparison against the model
	task automatic drive_and_check_commits();
		int      stretch;
		logic    level;
		logic    held;
		commit_t held_commit;
		commit_t exp;
		stretch     = 0;
		level       = 1'b0;
		held        = 1'b0;
		held_commit = '0;
		forever begin
			@(negedge clk);
			if (held) begin
				check_value("commit_valid", commit_valid, 1'b1);
				check_value("commit", commit, held_commit);
			end
			if (done) begin
				check_value("commit count at done", commit_count, expected_total);
			end
			if (stretch == 0) begin
				level   = 1'($urandom_range(0, 1));
				stretch = $urandom_range(1, 24);
			end
			stretch--;
			commit_ready = level;
			held         = commit_valid && !level;
			held_commit  = commit;
			if (commit_valid && level) begin
				if (expect_q.size() == 0) begin
					stop_with_error("commit seen with no model write pending");
				end else begin
					exp = expect_q.pop_front();
					check_value("commit.rd", commit.rd, exp.rd);
					check_value("commit.data", commit.data, exp.data);
					commit_count++;
				end
			end
		end
	endtask

	initial begin
		void'($urandom(94));
		arst_n         = 1'b0;
		run            = 1'b0;
		load_valid     = 1'b0;
		load_inst      = '0;
		commit_ready   = 1'b0;
		commit_count   = 0;
		expected_total = 0;
		foreach (model_regs[i]) begin
			model_regs[i] = '0;
		end
		repeat (4) @(negedge clk);
		check_value("commit_valid", commit_valid, 1'b0);
		check_value("done", done, 1'b0);
		check_value("load_ready", load_ready, 1'b0);
		arst_n = 1'b1;
		fork
			drive_and_check_commits();
		join_none
		@(negedge clk);
		check_value("commit_valid", commit_valid, 1'b0);
		check_value("done", done, 1'b0);

		// first program fills the whole store
		build_program(`OOO_IMEM_DEPTH);
		load_program();
		check_value("load_ready when full", load_ready, 1'b0);
		execute_program();

		// second program starts from the registers the first one left
		run = 1'b0;
		wait_for_load_ready();
		build_program(24);
		load_program();
		check_value("load_ready", load_ready, 1'b1);
		execute_program();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/add_sub.sv */
`default_nettype none

`include "ooo_settings.svh"

module add_sub import ooo_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     issue_valid,
	output logic     issue_ready,
	input  opcode_t  issue_op,
	input  rob_tag_t issue_tag,
	input  operand_t src_a,
	input  operand_t src_b,
	output cdb_t     cdb
);

	localparam int SLOTS = `OOO_RS_DEPTH;

	typedef logic [$clog2(SLOTS)-1:0] slot_idx_t;
	typedef logic [$clog2(SLOTS+1)-1:0] slot_cnt_t;

	typedef struct packed {
		opcode_t  op;
		rob_tag_t tag;
		operand_t a;
		operand_t b;
	} slot_t;

	// valid slots are packed from index 0, oldest first
	slot_t            slot_q [SLOTS];
	slot_t            slot_upd [SLOTS];
	slot_t            slot_nxt [SLOTS];
	logic [SLOTS-1:0] valid_q;
	logic [SLOTS-1:0] valid_nxt;
	slot_t            new_slot;
	logic             issue_fire;
	logic             dispatch;
	slot_idx_t        sel;
	slot_cnt_t        used;
	slot_cnt_t        fill;
	logic             res_valid_q;
	rob_tag_t         res_tag_q;
	data_t            res_data_q;

	function automatic operand_t snoop(operand_t src, cdb_t bus);
		operand_t res;
		res = src;
		if (!src.ready && bus.valid && bus.tag == src.tag) begin
			res.ready = 1'b1;
			res.value = bus.data;
		end
		return res;
	endfunction

	assign issue_ready = !valid_q[SLOTS-1];
	assign issue_fire  = issue_valid && issue_ready;

	assign new_slot.op  = issue_op;
	assign new_slot.tag = issue_tag;
	assign new_slot.a   = src_a;
	assign new_slot.b   = src_b;

	// capture operands from the bus, our own result included
	always_comb begin
		for (int i = 0; i < SLOTS; i++) begin
			slot_upd[i]   = slot_q[i];
			slot_upd[i].a = snoop(slot_q[i].a, cdb);
			slot_upd[i].b = snoop(slot_q[i].b, cdb);
		end
	end

	// lowest ready index is the oldest
	always_comb begin
		dispatch = 1'b0;
		sel      = '0;
		used     = '0;
		for (int i = SLOTS - 1; i >= 0; i--) begin
			if (valid_q[i] && slot_upd[i].a.ready && slot_upd[i].b.ready) begin
				dispatch = 1'b1;
				sel      = slot_idx_t'(i);
			end
		end
		for (int i = 0; i < SLOTS; i++) begin
			used = used + slot_cnt_t'(valid_q[i]);
		end
	end

	assign fill = used - slot_cnt_t'(dispatch);

	// close the gap left by dispatch, then append the new entry
	always_comb begin
		slot_nxt  = slot_upd;
		valid_nxt = valid_q;
		if (dispatch) begin
			for (int i = 0; i < SLOTS - 1; i++) begin
				if (i >= int'(sel)) begin
					slot_nxt[i]  = slot_upd[i + 1];
					valid_nxt[i] = valid_q[i + 1];
				end
			end
			valid_nxt[SLOTS-1] = 1'b0;
		end
		if (issue_fire) begin
			slot_nxt[slot_idx_t'(fill)]  = new_slot;
			valid_nxt[slot_idx_t'(fill)] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q     <= '0;
			res_valid_q <= 1'b0;
		end else begin
			valid_q     <= valid_nxt;
			res_valid_q <= dispatch;
		end
	end

	always_ff @(posedge clk) begin
		slot_q <= slot_nxt;
		if (dispatch) begin
			res_tag_q <= slot_upd[sel].tag;
			if (slot_upd[sel].op == OP_SUB) begin
				res_data_q <= slot_upd[sel].a.value - slot_upd[sel].b.value;
			end else begin
				res_data_q <= slot_upd[sel].a.value + slot_upd[sel].b.value;
			end
		end
	end

	// single producer, so the bus is never refused
	assign cdb.valid = res_valid_q;
	assign cdb.tag   = res_tag_q;
	assign cdb.data  = res_data_q;

endmodule

`default_nettype wire

/* source/inst_store.sv */
`default_nettype none

`include "ooo_settings.svh"

module inst_store import ooo_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  inst_t      load_inst,
	input  logic       load_we,
	input  logic       restart,
	input  logic       clear,
	input  logic       advance,
	output inst_t      inst,
	output imem_addr_t pc,
	output logic       at_end,
	output logic       full
);

	inst_t  mem [`OOO_IMEM_DEPTH];
	count_t length_q;
	count_t pc_q;
	count_t pc_next;
	inst_t  inst_q;

	assign full = length_q == count_t'(`OOO_IMEM_DEPTH);

	// program length, grows in load mode
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			length_q <= '0;
		end else if (clear) begin
			length_q <= '0;
		end else if (load_we && !full) begin
			length_q <= length_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_we && !full) begin
			mem[imem_addr_t'(length_q)] <= load_inst;
		end
	end

	assign pc_next = (restart || clear) ? '0 :
	                 advance            ? pc_q + 1'b1 : pc_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_next;
		end
	end

	// fetch register follows the next pc, so inst matches pc_q
	always_ff @(posedge clk) begin
		inst_q <= mem[imem_addr_t'(pc_next)];
	end

	assign inst   = inst_q;
	assign pc     = imem_addr_t'(pc_q);
	assign at_end = pc_q >= length_q;

endmodule

`default_nettype wire

/* source/ooo_core.sv */
`default_nettype none

`include "ooo_settings.svh"

module ooo_core import ooo_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  inst_t   load_inst,
	input  logic    load_valid,
	output logic    load_ready,
	input  logic    run,
	output commit_t commit,
	output logic    commit_valid,
	input  logic    commit_ready,
	output logic    done
);

	mode_t      mode_q;
	mode_t      next_mode;
	logic       mode_change;
	logic       fetch_wait_q;
	logic       exec;
	inst_t      inst;
	logic       at_end;
	logic       full;
	logic       issue_valid;
	logic       issue_ready;
	logic       issue_fire;
	logic       alloc_ready;
	rob_tag_t   alloc_tag;
	rob_tag_t   commit_tag;
	logic       rob_empty;
	operand_t   rs_read;
	operand_t   rt_read;
	operand_t   rob_read_a;
	operand_t   rob_read_b;
	operand_t   src_a;
	operand_t   src_b;
	cdb_t       cdb;
	data_t      imm_ext;

	////////////////////////////////////////////////////////////////////////////
	// mode
	////////////////////////////////////////////////////////////////////////////

	assign next_mode   = run ? MODE_EXEC : MODE_LOAD;
	assign mode_change = next_mode != mode_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode_q       <= MODE_LOAD;
			fetch_wait_q <= 1'b0;
		end else begin
			mode_q       <= next_mode;
			fetch_wait_q <= mode_change;
		end
	end

	// first exec cycle waits for the fetch of address zero
	assign exec       = mode_q == MODE_EXEC && !fetch_wait_q;
	assign load_ready = arst_n && mode_q == MODE_LOAD && !full;
	assign done       = exec && at_end && rob_empty;

	inst_store inst_store (
		.clk,
		.arst_n,
		.load_inst,
		.load_we(load_valid && load_ready),
		.restart(mode_change && run),
		.clear(mode_change && !run),
		.advance(issue_fire),
		.inst,
		.pc(),
		.at_end,
		.full
	);

	////////////////////////////////////////////////////////////////////////////
	// decode, issue and operand merge
	////////////////////////////////////////////////////////////////////////////

	assign issue_valid = exec && !at_end && alloc_ready;
	assign issue_fire  = issue_valid && issue_ready;
	assign imm_ext     = {{(`OOO_DATA_W - 16){inst.imm[15]}}, inst.imm};

	// busy source: take it from a finished ROB entry or the bus this cycle
	function automatic operand_t merge(operand_t arch, operand_t from_rob, cdb_t bus);
		operand_t res;
		res = arch;
		if (!arch.ready) begin
			if (from_rob.ready) begin
				res.ready = 1'b1;
				res.value = from_rob.value;
			end else if (bus.valid && bus.tag == arch.tag) begin
				res.ready = 1'b1;
				res.value = bus.data;
			end
		end
		return res;
	endfunction

	assign src_a = merge(rs_read, rob_read_a, cdb);

	always_comb begin
		if (inst.op == OP_ADDI) begin
			src_b.ready = 1'b1;
			src_b.tag   = '0;
			src_b.value = imm_ext;
		end else begin
			src_b = merge(rt_read, rob_read_b, cdb);
		end
	end

	register_file register_file (
		.clk,
		.arst_n,
		.rs_idx(inst.rs),
		.rt_idx(inst.rt),
		.rs_read,
		.rt_read,
		.issue(issue_fire),
		.issue_rd(inst.rd),
		.issue_tag(alloc_tag),
		.commit_en(commit_valid && commit_ready),
		.commit,
		.commit_tag
	);

	rob rob (
		.clk,
		.arst_n,
		.alloc(issue_fire),
		.alloc_rd(inst.rd),
		.alloc_ready,
		.alloc_tag,
		.cdb,
		.read_tag_a(rs_read.tag),
		.read_tag_b(rt_read.tag),
		.read_a(rob_read_a),
		.read_b(rob_read_b),
		.commit,
		.commit_tag,
		.commit_valid,
		.commit_ready,
		.empty(rob_empty)
	);

	add_sub add_sub (
		.clk,
		.arst_n,
		.issue_valid,
		.issue_ready,
		.issue_op(inst.op),
		.issue_tag(alloc_tag),
		.src_a,
		.src_b,
		.cdb
	);

endmodule

`default_nettype wire

/* source/ooo_pkg.sv */
`default_nettype none

`include "ooo_settings.svh"

package ooo_pkg;

	typedef logic [`OOO_DATA_W-1:0] data_t;
	typedef logic [$clog2(`OOO_REG_COUNT)-1:0] reg_idx_t;
	typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;
	typedef logic [$clog2(`OOO_IMEM_DEPTH)-1:0] imem_addr_t;
	// one extra bit so a full store can be counted
	typedef logic [$clog2(`OOO_IMEM_DEPTH):0] count_t;

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_ADDI
	} opcode_t;

	// addi ignores rt
	typedef struct packed {
		opcode_t            op;
		reg_idx_t           rd;
		reg_idx_t           rs;
		reg_idx_t           rt;
		logic [1:0]         spare;
		logic signed [15:0] imm;
	} inst_t;

	// tag is only meaningful while ready is low
	typedef struct packed {
		logic     ready;
		rob_tag_t tag;
		data_t    value;
	} operand_t;

	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		data_t    data;
	} cdb_t;

	typedef struct packed {
		reg_idx_t rd;
		data_t    data;
	} commit_t;

	typedef enum logic {
		MODE_LOAD,
		MODE_EXEC
	} mode_t;

endpackage

`default_nettype wire

/* source/ooo_settings.svh */
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath
////////////////////////////////////////////////////////////////////////////

`define OOO_DATA_W 32

// architectural registers
`define OOO_REG_COUNT 16

////////////////////////////////////////////////////////////////////////////
// queue depths
////////////////////////////////////////////////////////////////////////////

// must stay a power of two so the ROB pointers wrap
`define OOO_ROB_DEPTH 8
`define OOO_IMEM_DEPTH 64
`define OOO_RS_DEPTH 2

`endif

/* source/register_file.sv */
`default_nettype none

`include "ooo_settings.svh"

module register_file import ooo_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t rs_idx,
	input  reg_idx_t rt_idx,
	output operand_t rs_read,
	output operand_t rt_read,
	input  logic     issue,
	input  reg_idx_t issue_rd,
	input  rob_tag_t issue_tag,
	input  logic     commit_en,
	input  commit_t  commit,
	input  rob_tag_t commit_tag
);

	data_t                     value_q [`OOO_REG_COUNT];
	rob_tag_t                  tag_q [`OOO_REG_COUNT];
	logic [`OOO_REG_COUNT-1:0] busy_q;

	function automatic operand_t read_reg(reg_idx_t idx);
		operand_t res;
		res.ready = !busy_q[idx];
		res.tag   = tag_q[idx];
		res.value = value_q[idx];
		return res;
	endfunction

	assign rs_read = read_reg(rs_idx);
	assign rt_read = read_reg(rt_idx);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= '0;
			for (int i = 0; i < `OOO_REG_COUNT; i++) begin
				value_q[i] <= '0;
				tag_q[i]   <= '0;
			end
		end else begin
			if (commit_en) begin
				value_q[commit.rd] <= commit.data;
				// a younger rename of rd keeps the register busy
				if (tag_q[commit.rd] == commit_tag) begin
					busy_q[commit.rd] <= 1'b0;
				end
			end
			// issue last, so a same-cycle rename wins over the commit
			if (issue) begin
				busy_q[issue_rd] <= 1'b1;
				tag_q[issue_rd]  <= issue_tag;
			end
		end
	end

endmodule

`default_nettype wire

/* source/rob.sv */
`default_nettype none

`include "ooo_settings.svh"

module rob import ooo_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     alloc,
	input  reg_idx_t alloc_rd,
	output logic     alloc_ready,
	output rob_tag_t alloc_tag,
	input  cdb_t     cdb,
	input  rob_tag_t read_tag_a,
	input  rob_tag_t read_tag_b,
	output operand_t read_a,
	output operand_t read_b,
	output commit_t  commit,
	output rob_tag_t commit_tag,
	output logic     commit_valid,
	input  logic     commit_ready,
	output logic     empty
);

	localparam int DEPTH = `OOO_ROB_DEPTH;

	typedef logic [$clog2(DEPTH):0] rob_count_t;

	rob_tag_t         head_q;
	rob_tag_t         tail_q;
	rob_count_t       count_q;
	logic [DEPTH-1:0] done_q;
	reg_idx_t         rd_q [DEPTH];
	data_t            data_q [DEPTH];
	logic             retire;

	assign alloc_ready = count_q != rob_count_t'(DEPTH);
	assign alloc_tag   = tail_q;
	assign empty       = count_q == '0;

	////////////////////////////////////////////////////////////////////////////
	// head presentation
	////////////////////////////////////////////////////////////////////////////

	assign commit_valid = !empty && done_q[head_q];
	assign commit.rd    = rd_q[head_q];
	assign commit.data  = data_q[head_q];
	assign commit_tag   = head_q;
	assign retire       = commit_valid && commit_ready;

	function automatic operand_t read_entry(rob_tag_t tag);
		operand_t res;
		res.ready = done_q[tag];
		res.tag   = tag;
		res.value = data_q[tag];
		return res;
	endfunction

	assign read_a = read_entry(read_tag_a);
	assign read_b = read_entry(read_tag_b);

	////////////////////////////////////////////////////////////////////////////
	// pointers and done flags
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			done_q  <= '0;
		end else begin
			if (alloc) begin
				done_q[tail_q] <= 1'b0;
				tail_q         <= tail_q + 1'b1;
			end
			if (cdb.valid) begin
				done_q[cdb.tag] <= 1'b1;
			end
			if (retire) begin
				head_q <= head_q + 1'b1;
			end
			count_q <= count_q + rob_count_t'(alloc) - rob_count_t'(retire);
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			rd_q[tail_q] <= alloc_rd;
		end
		if (cdb.valid) begin
			data_q[cdb.tag] <= cdb.data;
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/ooo_pkg.sv
source/inst_store.sv
source/register_file.sv
source/rob.sv
source/add_sub.sv
source/ooo_core.sv
dv/ooo_core_assertions.sv
dv/ooo_core_tb.sv
